/* dupTagTop.f */
+incdir+verilog
verilog/stubPkg.sv
verilog/pairPkg.sv
verilog/trackPairAligner.sv
verilog/pairFifo.sv
verilog/duplicateTagger.sv
verilog/dupTagTop.sv
verification/clockGen.sv
verification/dupTagTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the duplicate tagger testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dupTagTb \
    -f dupTagTop.f --Mdir obj_dir > build.log 2>&1 \
    || { cat build.log; echo "Verilator build error"; exit 1; }

./obj_dir/VdupTagTb > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || { echo "no result found in sim.log"; exit 1; }

/* verification/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic arstN
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Reset held over the first three rising edges
    initial begin
        arstN = 1'b0;
        repeat (3) begin
            @(posedge clk);
        end
        #1;
        arstN = 1'b1;
    end

endmodule

`default_nettype wire

/* verification/dupTagTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "trackDefs_consts.svh"

module dupTagTb;

    localparam int timeoutCycles = 200;
    localparam int patternLen    = 256;

    logic               clk;
    logic               arstN;
    pairPkg::pairInT    inPair;
    logic               inValid;
    logic               inReady;
    pairPkg::tagResultT outResult;
    logic               outValid;
    logic               outReady;

    pairPkg::tagResultT expQ[$];
    logic               readyPattern[patternLen];
    logic               stallOn;
    string              testName;
    int                 nSent;
    int                 nChecked;

    clockGen u_clk (
        .clk   (clk),
        .arstN (arstN)
    );

    dupTagTop u_dut (
        .clk       (clk),
        .arstN     (arstN),
        .inPair    (inPair),
        .inValid   (inValid),
        .inReady   (inReady),
        .outResult (outResult),
        .outValid  (outValid),
        .outReady  (outReady)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkValue(input string what, input int expected, input int actual);
        string line;
        if (expected != actual) begin
            line = $sformatf("Mismatch in %s, %s: expected %0d, actual %0d",
                             testName, what, expected, actual);
            abortRun(line);
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Seed layers first, then the other four ascending
    function automatic int layerOfSlot(input int seed, input int slot);
        int rest;
        if (seed >= `NUM_BARREL_SEEDS) begin
            return slot;
        end
        if (slot < 2) begin
            return 2 * seed + slot;
        end
        rest = slot - 2;
        return (rest < 2 * seed) ? rest : rest + 2;
    endfunction

    function automatic pairPkg::tagResultT modelResult(input pairPkg::pairInT p);
        logic [`STUB_WIDTH-1:0] lay1 [`STUBS_PER_TRACK];
        logic [`STUB_WIDTH-1:0] lay2 [`STUBS_PER_TRACK];
        logic                   bothBarrel;
        logic                   hit1;
        logic                   hit2;
        logic                   differ;
        int                     nStub1;
        int                     nStub2;
        int                     nInd1;
        int                     nInd2;
        pairPkg::tagResultT     r;
        nStub1 = 0;
        nStub2 = 0;
        nInd1  = 0;
        nInd2  = 0;
        for (int slot = 0; slot < `STUBS_PER_TRACK; slot++) begin
            lay1[layerOfSlot(int'(p.seed1), slot)] = p.track1[slot];
            lay2[layerOfSlot(int'(p.seed2), slot)] = p.track2[slot];
        end
        bothBarrel = (p.seed1 < `NUM_BARREL_SEEDS) && (p.seed2 < `NUM_BARREL_SEEDS);
        for (int l = 0; l < `STUBS_PER_TRACK; l++) begin
            hit1   = (lay1[l] != '1);
            hit2   = (lay2[l] != '1);
            differ = (lay1[l] != lay2[l]);
            nStub1 += int'(hit1);
            nStub2 += int'(hit2);
            nInd1  += int'(hit1 && (!bothBarrel || differ));
            nInd2  += int'(hit2 && (!bothBarrel || differ));
        end
        // A tie on hit count tags track 2
        r.track1Dup = p.dupIn1 ||
            (!p.dupIn2 && (nInd1 < `IND_STUB_LIMIT) && (nStub1 < nStub2));
        r.track2Dup = p.dupIn2 ||
            (!p.dupIn1 && (nInd2 < `IND_STUB_LIMIT) && (nStub2 <= nStub1));
        r.nInd1 = stubPkg::countT'(nInd1);
        r.nInd2 = stubPkg::countT'(nInd2);
        return r;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    function automatic logic [`STUB_WIDTH-1:0] randomStub(input int missPct);
        if ($urandom_range(99) < missPct) begin
            return '1;
        end
        return `STUB_WIDTH'($urandom_range((1 << `STUB_WIDTH) - 2));
    endfunction

    function automatic pairPkg::pairInT randomPair(input int seed1, input int seed2,
                                                   input int missPct, input int copyPct,
                                                   input logic randomFlags);
        pairPkg::pairInT p;
        int              src;
        src     = 0;
        p.seed1 = stubPkg::seedT'(seed1);
        p.seed2 = stubPkg::seedT'(seed2);
        for (int slot = 0; slot < `STUBS_PER_TRACK; slot++) begin
            p.track1[slot] = randomStub(missPct);
            p.track2[slot] = randomStub(missPct);
        end
        // Copy track 1's stub into the track 2 slot of the same layer
        for (int slot2 = 0; slot2 < `STUBS_PER_TRACK; slot2++) begin
            if ($urandom_range(99) < copyPct) begin
                for (int slot1 = 0; slot1 < `STUBS_PER_TRACK; slot1++) begin
                    if (layerOfSlot(seed1, slot1) == layerOfSlot(seed2, slot2)) begin
                        src = slot1;
                    end
                end
                p.track2[slot2] = p.track1[src];
            end
        end
        p.dupIn1 = randomFlags && ($urandom_range(1) == 1);
        p.dupIn2 = randomFlags && ($urandom_range(1) == 1);
        return p;
    endfunction

    // Called 1 ns after a rising edge, returns 1 ns after the transfer edge
    task automatic sendPair(input pairPkg::pairInT p);
        int waited;
        waited  = 0;
        inPair  = p;
        inValid = 1'b1;
        @(negedge clk);
        while (!inReady) begin
            waited++;
            if (waited > timeoutCycles) begin
                abortRun("Timeout: the DUT did not accept an input pair");
            end
            @(negedge clk);
        end
        expQ.push_back(modelResult(p));
        nSent++;
        @(posedge clk);
        #1;
        inValid = 1'b0;
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expQ.size() != 0) begin
            waited++;
            if (waited > timeoutCycles * 4) begin
                abortRun("Timeout: results still missing after the last pair was sent");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    // Output ready is random only while stalls are on
    initial begin
        int cycle;
        cycle = 0;
        forever begin
            @(posedge clk);
            #1;
            outReady = stallOn ? readyPattern[cycle % patternLen] : 1'b1;
            cycle++;
        end
    end

    // Result monitor samples the handshake mid-cycle
    initial begin
        pairPkg::tagResultT exp;
        forever begin
            @(negedge clk);
            if (arstN && outValid && outReady) begin
                if (expQ.size() == 0) begin
                    abortRun("The DUT produced a result with no pair pending");
                end else begin
                    exp = expQ.pop_front();
                    checkValue("track1Dup", exp.track1Dup, outResult.track1Dup);
                    checkValue("track2Dup", exp.track2Dup, outResult.track2Dup);
                    checkValue("nInd1", exp.nInd1, outResult.nInd1);
                    checkValue("nInd2", exp.nInd2, outResult.nInd2);
                    nChecked++;
                end
            end
        end
    end

    initial begin
        pairPkg::pairInT    p;
        pairPkg::tagResultT r;
        int                 waited;
        int                 seed1;
        int                 seed2;
        int                 gap;
        void'($urandom(32'he720_524a));
        inPair   = '0;
        inValid  = 1'b0;
        outReady = 1'b1;
        stallOn  = 1'b0;
        nSent    = 0;
        nChecked = 0;
        waited   = 0;
        testName = "reset";
        for (int k = 0; k < patternLen; k++) begin
            readyPattern[k] = ($urandom_range(99) < 60);
        end

        while (arstN !== 1'b1) begin
            waited++;
            if (waited > timeoutCycles) begin
                abortRun("Timeout: reset was never released");
            end
            @(posedge clk);
        end
        @(negedge clk);
        checkValue("inReady", 1, inReady);
        checkValue("outValid", 0, outValid);
        @(posedge clk);
        #1;

        testName = "identical tracks";
        for (int s = 0; s < `NUM_BARREL_SEEDS; s++) begin
            p = randomPair(s, s, 0, 100, 1'b0);
            r = modelResult(p);
            checkValue("model nInd1", 0, r.nInd1);
            checkValue("model nInd2", 0, r.nInd2);
            checkValue("model flags", 2'b01, {r.track1Dup, r.track2Dup});
            sendPair(p);
        end
        waitDrain();

        testName = "random barrel";
        for (int n = 0; n < 200; n++) begin
            seed1 = $urandom_range(`NUM_BARREL_SEEDS - 1);
            seed2 = $urandom_range(`NUM_BARREL_SEEDS - 1);
            sendPair(randomPair(seed1, seed2, $urandom_range(40), 50, 1'b0));
        end
        waitDrain();

        testName = "non-barrel seed";
        for (int n = 0; n < 60; n++) begin
            seed1 = (n % 3 != 1) ? $urandom_range(15, 3) : $urandom_range(2);
            seed2 = (n % 3 != 0) ? $urandom_range(15, 3) : $urandom_range(2);
            sendPair(randomPair(seed1, seed2, $urandom_range(30), 100, 1'b0));
        end
        waitDrain();

        testName = "flags and stalls";
        stallOn  = 1'b1;
        for (int n = 0; n < 150; n++) begin
            seed1 = ($urandom_range(3) == 0) ? $urandom_range(15) : $urandom_range(2);
            seed2 = ($urandom_range(3) == 0) ? $urandom_range(15) : $urandom_range(2);
            sendPair(randomPair(seed1, seed2, $urandom_range(40), 60, 1'b1));
            gap = $urandom_range(2);
            if (gap > 0) begin
                repeat (gap) begin
                    @(posedge clk);
                end
                #1;
            end
        end
        waitDrain();
        stallOn = 1'b0;

        testName = "final count";
        @(negedge clk);
        checkValue("results received", nSent, nChecked);
        if (!outValid) begin
            $display("test passed");
            $finish;
        end else begin
            abortRun("The DUT still held a result after every pair was checked");
        end
    end

endmodule

`default_nettype wire

/* verilog/dupTagTop.sv */
`timescale 1ns/1ps
`default_nettype none

module dupTagTop (
    input  logic               clk,
    input  logic               arstN,
    input  pairPkg::pairInT    inPair,
    input  logic               inValid,
    output logic               inReady,
    output pairPkg::tagResultT outResult,
    output logic               outValid,
    input  logic               outReady
);

    pairPkg::alignedPairT alPair;
    logic                 alValid;
    logic                 alReady;

    pairPkg::alignedPairT fifoPair;
    logic                 fifoValid;
    logic                 fifoReady;

    trackPairAligner u_aligner (
        .clk     (clk),
        .arstN   (arstN),
        .inPair  (inPair),
        .inValid (inValid),
        .inReady (inReady),
        .alPair  (alPair),
        .alValid (alValid),
        .alReady (alReady)
    );

    // Absorbs output stalls before they reach the input
    pairFifo u_fifo (
        .clk      (clk),
        .arstN    (arstN),
        .inPair   (alPair),
        .inValid  (alValid),
        .inReady  (alReady),
        .outPair  (fifoPair),
        .outValid (fifoValid),
        .outReady (fifoReady)
    );

    duplicateTagger u_tagger (
        .clk       (clk),
        .arstN     (arstN),
        .inPair    (fifoPair),
        .inValid   (fifoValid),
        .inReady   (fifoReady),
        .outResult (outResult),
        .outValid  (outValid),
        .outReady  (outReady)
    );

endmodule

`default_nettype wire

/* verilog/duplicateTagger.sv */
`timescale 1ns/1ps
`default_nettype none

`include "trackDefs_consts.svh"

module duplicateTagger (
    input  logic                 clk,
    input  logic                 arstN,
    input  pairPkg::alignedPairT inPair,
    input  logic                 inValid,
    output logic                 inReady,
    output pairPkg::tagResultT   outResult,
    output logic                 outValid,
    input  logic                 outReady
);

    stubPkg::layerMaskT diffMask;
    stubPkg::layerMaskT ind1;
    stubPkg::layerMaskT ind2;
    stubPkg::countT     nInd1;
    stubPkg::countT     nInd2;
    stubPkg::countT     nStub1;
    stubPkg::countT     nStub2;
    pairPkg::tagResultT nextResult;
    logic               accept;

    //////////////////////////////////////////////////
    // Independent stubs
    //////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < `STUBS_PER_TRACK; k++) begin
            diffMask[k] = (inPair.track1.layer[k] != inPair.track2.layer[k]);
        end
    end

    // Without two barrel seeds there is no comparison
    assign ind1 = inPair.bothBarrel ? (inPair.track1.hitMask & diffMask)
                                    : inPair.track1.hitMask;
    assign ind2 = inPair.bothBarrel ? (inPair.track2.hitMask & diffMask)
                                    : inPair.track2.hitMask;

    assign nInd1  = stubPkg::countBits(ind1);
    assign nInd2  = stubPkg::countBits(ind2);
    assign nStub1 = inPair.track1.hitCount;
    assign nStub2 = inPair.track2.hitCount;

    //////////////////////////////////////////////////
    // Decision
    //////////////////////////////////////////////////

    // Equal hit counts tag track 2, so track 1 wins a tie
    always_comb begin
        nextResult.track1Dup = inPair.dupIn1 ||
            (!inPair.dupIn2 && (nInd1 < `IND_STUB_LIMIT) && (nStub1 < nStub2));
        nextResult.track2Dup = inPair.dupIn2 ||
            (!inPair.dupIn1 && (nInd2 < `IND_STUB_LIMIT) && (nStub2 <= nStub1));
        nextResult.nInd1 = nInd1;
        nextResult.nInd2 = nInd2;
    end

    assign inReady = !outValid || outReady;
    assign accept  = inValid && inReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else if (accept) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outResult <= nextResult;
        end
    end

    holdUnderStall : assert property (
        @(posedge clk) disable iff (!arstN)
        (outValid && !outReady) |=> (outValid && $stable(outResult))
    );

endmodule

`default_nettype wire

/* verilog/pairFifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "trackDefs_consts.svh"

module pairFifo #(
    parameter int depth = `FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  pairPkg::alignedPairT inPair,
    input  logic                 inValid,
    output logic                 inReady,
    output pairPkg::alignedPairT outPair,
    output logic                 outValid,
    input  logic                 outReady
);

    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntWidth = $clog2(depth + 1);

    pairPkg::alignedPairT mem [depth];
    logic [ptrWidth-1:0]  wrPtr;
    logic [ptrWidth-1:0]  rdPtr;
    logic [cntWidth-1:0]  count;
    logic                 push;
    logic                 pop;

    // Wraps at depth, so depth need not be a power of two
    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign inReady  = (count != cntWidth'(depth));
    assign outValid = (count != '0);
    assign push     = inValid && inReady;
    assign pop      = outValid && outReady;
    assign outPair  = mem[rdPtr];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inPair;
        end
    end

    noPushWhenFull : assert property (
        @(posedge clk) disable iff (!arstN) (count == depth) |-> !push
    );

    noPopWhenEmpty : assert property (
        @(posedge clk) disable iff (!arstN) (count == 0) |-> !pop
    );

endmodule

`default_nettype wire

/* verilog/pairPkg.sv */
`default_nettype none

package pairPkg;

    //////////////////////////////////////////////////
    // Pair as it arrives at the input
    //////////////////////////////////////////////////

    typedef struct packed {
        stubPkg::trackT track1;
        stubPkg::trackT track2;
        stubPkg::seedT  seed1;
        stubPkg::seedT  seed2;
        logic           dupIn1;
        logic           dupIn2;
    } pairInT;

    //////////////////////////////////////////////////
    // Stage records
    //////////////////////////////////////////////////

    // Both tracks in layer order
    typedef struct packed {
        stubPkg::alignedTrackT track1;
        stubPkg::alignedTrackT track2;
        logic                  bothBarrel;
        logic                  dupIn1;
        logic                  dupIn2;
    } alignedPairT;

    typedef struct packed {
        logic          track1Dup;
        logic          track2Dup;
        stubPkg::countT nInd1;
        stubPkg::countT nInd2;
    } tagResultT;

endpackage

`default_nettype wire

/* verilog/stubPkg.sv */
`default_nettype none

`include "trackDefs_consts.svh"

package stubPkg;

    // All ones marks a missed hit
    typedef logic [`STUB_WIDTH-1:0] stubT;

    typedef logic [`SEED_WIDTH-1:0] seedT;

    typedef logic [`COUNT_WIDTH-1:0] countT;

    // Bit k belongs to layer k
    typedef logic [`STUBS_PER_TRACK-1:0] layerMaskT;

    // Slot 0 sits in the highest bits
    typedef stubT [0:`STUBS_PER_TRACK-1] trackT;

    typedef struct packed {
        stubT [0:`STUBS_PER_TRACK-1] layer;
        layerMaskT                   hitMask;
        countT                       hitCount;
    } alignedTrackT;

    function automatic countT countBits(input layerMaskT mask);
        countT total;
        total = '0;
        for (int k = 0; k < `STUBS_PER_TRACK; k++) begin
            total = total + countT'(mask[k]);
        end
        return total;
    endfunction

endpackage

`default_nettype wire

/* verilog/trackDefs_consts.svh */
`ifndef TRACK_DEFS_CONSTS_SVH
`define TRACK_DEFS_CONSTS_SVH

// Stub word and track geometry
`define STUB_WIDTH 9
`define STUBS_PER_TRACK 6

// Seed codes below NUM_BARREL_SEEDS are barrel seeds
`define SEED_WIDTH 4
`define NUM_BARREL_SEEDS 3

// Tagging threshold on independent stubs
`define IND_STUB_LIMIT 3
`define COUNT_WIDTH 3

// Buffer between aligner and tagger
`define FIFO_DEPTH 4

`endif

/* verilog/trackPairAligner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "trackDefs_consts.svh"

module trackPairAligner (
    input  logic                 clk,
    input  logic                 arstN,
    input  pairPkg::pairInT      inPair,
    input  logic                 inValid,
    output logic                 inReady,
    output pairPkg::alignedPairT alPair,
    output logic                 alValid,
    input  logic                 alReady
);

    function automatic logic isBarrel(input stubPkg::seedT seed);
        return seed < stubPkg::seedT'(`NUM_BARREL_SEEDS);
    endfunction

    // Slots 0 and 1 carry the seed layers, slots 2 to 5 the others ascending
    function automatic stubPkg::alignedTrackT alignTrack(input stubPkg::trackT raw,
                                                         input stubPkg::seedT seed);
        stubPkg::alignedTrackT res;
        if (seed == stubPkg::seedT'(1)) begin
            // L3L4 seed
            res.layer = {raw[2], raw[3], raw[0], raw[1], raw[4], raw[5]};
        end else if (seed == stubPkg::seedT'(2)) begin
            // L5L6 seed
            res.layer = {raw[2], raw[3], raw[4], raw[5], raw[0], raw[1]};
        end else begin
            // L1L2 is already in layer order, other seeds stay as slots
            res.layer = raw;
        end
        for (int k = 0; k < `STUBS_PER_TRACK; k++) begin
            res.hitMask[k] = ~&res.layer[k];
        end
        res.hitCount = stubPkg::countBits(res.hitMask);
        return res;
    endfunction

    pairPkg::alignedPairT nextPair;
    logic                 accept;

    //////////////////////////////////////////////////
    // Unpack and reorder
    //////////////////////////////////////////////////

    always_comb begin
        nextPair.track1     = alignTrack(inPair.track1, inPair.seed1);
        nextPair.track2     = alignTrack(inPair.track2, inPair.seed2);
        nextPair.bothBarrel = isBarrel(inPair.seed1) && isBarrel(inPair.seed2);
        nextPair.dupIn1     = inPair.dupIn1;
        nextPair.dupIn2     = inPair.dupIn2;
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    assign inReady = !alValid || alReady;
    assign accept  = inValid && inReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            alValid <= 1'b0;
        end else if (accept) begin
            alValid <= 1'b1;
        end else if (alReady) begin
            alValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alPair <= nextPair;
        end
    end

    // Counts feed the tagger's comparisons downstream
    hitCountBound : assert property (
        @(posedge clk) disable iff (!arstN)
        alValid |-> (alPair.track1.hitCount <= `STUBS_PER_TRACK) &&
                    (alPair.track2.hitCount <= `STUBS_PER_TRACK)
    );

endmodule

`default_nettype wire
